/* build.f */
+incdir+include
hw/dma_pkg.sv
hw/dma_engine.sv
hw/wb_addr_decoder.sv
hw/nv_memory.sv
hw/config_regs.sv
hw/value_store.sv
hw/dma_subsys.sv
test/tb_dma_subsys.sv

/* Bender.yml */
package:
  name: dma_subsys

sources:
  - include_dirs:
      - include
    files:
      - hw/dma_pkg.sv
      - hw/dma_engine.sv
      - hw/wb_addr_decoder.sv
      - hw/nv_memory.sv
      - hw/config_regs.sv
      - hw/value_store.sv
      - hw/dma_subsys.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_dma_subsys.sv

/* test/tb_dma_subsys.sv */
`timescale 1ns/1ps
`include "dma_defs.svh"

module tb_dma_subsys;

  localparam int boot_cycles     = 3 * (`DMA_LC_COUNT + `DMA_ACM_COUNT + 1);
  localparam int dump_cycles     = 3 * (`DMA_VS_DEPTH + 1) + 8;
  localparam int readback_cycles = `DMA_LC_COUNT + `DMA_ACM_COUNT + 1;
  localparam int prog_cycles     = `DMA_FROM_WORDS + 2;
  // Each of four boots is programmed, reset, copied and read back; two dumps run long.
  localparam int max_cycles = 4 * (prog_cycles + 10 + boot_cycles + readback_cycles +
                                   `DMA_VS_DEPTH + 1) +
                              2 * dump_cycles + 80 + 200;

  logic              wb_clk_i = 1'b0;
  logic              soft_reset;
  logic              dma_crash_i;
  logic              prog_we_i;
  dma_pkg::wb_addr_t prog_addr_i;
  dma_pkg::wb_data_t prog_data_i;
  logic              event_valid_i;
  dma_pkg::event_t   event_data_i;
  dma_pkg::wb_addr_t cfg_rd_addr_i;
  dma_pkg::wb_addr_t flash_rd_addr_i;
  logic              dma_done_o;
  dma_pkg::wb_data_t cfg_rd_data_o;
  dma_pkg::wb_data_t flash_rd_data_o;

  dma_pkg::wb_data_t from_shadow [`DMA_FROM_WORDS];
  dma_pkg::wb_data_t flash_sys_shadow;
  dma_pkg::event_t   event_log [$];
  logic [31:0]       rng_state = 32'ha4ba_8e48;
  int                errors = 0;
  int                checks = 0;
  int                cycle_count = 0;

  dma_subsys dma_subsys_inst (
    .wb_clk_i       (wb_clk_i),
    .soft_reset     (soft_reset),
    .dma_crash_i    (dma_crash_i),
    .prog_we_i      (prog_we_i),
    .prog_addr_i    (prog_addr_i),
    .prog_data_i    (prog_data_i),
    .event_valid_i  (event_valid_i),
    .event_data_i   (event_data_i),
    .cfg_rd_addr_i  (cfg_rd_addr_i),
    .flash_rd_addr_i(flash_rd_addr_i),
    .dma_done_o     (dma_done_o),
    .cfg_rd_data_o  (cfg_rd_data_o),
    .flash_rd_data_o(flash_rd_data_o)
  );

  always #4 wb_clk_i = ~wb_clk_i;

  always @(posedge wb_clk_i) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles.", max_cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic dma_pkg::wb_data_t expected_threshold(input dma_pkg::wb_data_t w);
    if (w == 16'h00ff) begin
      return 16'h0fff;
    end
    return w << 4;
  endfunction

  task automatic next_cycle();
    @(posedge wb_clk_i);
    #1;
  endtask

  task automatic check_value(input string name, input dma_pkg::wb_data_t got,
                             input dma_pkg::wb_data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic program_nv();
    dma_pkg::wb_data_t word;
    for (int i = 0; i < `DMA_FROM_WORDS; i++) begin
      rng_state = lcg_next(rng_state);
      word = rng_state[31:16];
      // A few 8'hff thresholds hit the special case.
      if (i >= `DMA_FROM_LC_A && i % 11 == 0) begin
        word = 16'h00ff;
      end
      from_shadow[i] = word;
      next_cycle();
      prog_we_i   = 1'b1;
      prog_addr_i = dma_pkg::wb_addr_t'(i);
      prog_data_i = word;
    end
    rng_state = lcg_next(rng_state);
    flash_sys_shadow = rng_state[31:16];
    next_cycle();
    prog_addr_i = `DMA_FLASH_SYSCONFIG_A;
    prog_data_i = flash_sys_shadow;
    next_cycle();
    prog_we_i = 1'b0;
  endtask

  task automatic log_events(input int count);
    dma_pkg::event_t ev;
    for (int k = 0; k < count; k++) begin
      rng_state = lcg_next(rng_state);
      ev = rng_state[30:16];
      next_cycle();
      event_valid_i = 1'b1;
      event_data_i  = ev;
      event_log.push_back(ev);
      // Only the newest entries stay in the ring.
      if (event_log.size() > `DMA_VS_DEPTH) begin
        void'(event_log.pop_front());
      end
    end
    next_cycle();
    event_valid_i = 1'b0;
  endtask

  task automatic run_boot(input logic crash);
    int n;
    next_cycle();
    soft_reset  = 1'b1;
    dma_crash_i = crash;
    repeat (8) begin
      next_cycle();
      check_value("dma_done_o", {15'd0, dma_done_o}, 16'd0);
    end
    soft_reset  = 1'b0;
    dma_crash_i = 1'b0;
    // First edge that sees soft_reset low.
    next_cycle();
    check_value("dma_done_o", {15'd0, dma_done_o}, 16'd0);
    n = 0;
    while (!dma_done_o && n < boot_cycles + dump_cycles + 16) begin
      next_cycle();
      n++;
    end
    checks++;
    assert (dma_done_o === 1'b1) else begin
      errors++;
      $display("Error at %0t: dma_done_o did not rise within %0d cycles of reset.", $time, n);
    end
    if (dma_done_o === 1'b1 && !crash) begin
      check_value("dma_done_o rise cycle", 16'(n), 16'(boot_cycles));
    end
  endtask

  task automatic read_config(input int addr, input dma_pkg::wb_data_t exp);
    next_cycle();
    cfg_rd_addr_i = dma_pkg::wb_addr_t'(addr);
    #1;
    check_value($sformatf("cfg_rd_data_o[%0d]", addr), cfg_rd_data_o, exp);
    check_value("dma_done_o", {15'd0, dma_done_o}, 16'd1);
  endtask

  task automatic check_config();
    for (int i = 0; i < `DMA_LC_COUNT; i++) begin
      read_config(`DMA_LC_THRESHS_A + i, expected_threshold(from_shadow[`DMA_FROM_LC_A + i]));
    end
    for (int i = 0; i < `DMA_ACM_COUNT; i++) begin
      read_config(`DMA_ACM_AQUADS_A + i, from_shadow[`DMA_FROM_ACM_A + i]);
    end
    read_config(`DMA_SYSCONFIG_A, flash_sys_shadow);
  endtask

  task automatic read_flash(input int idx, input dma_pkg::wb_data_t exp);
    next_cycle();
    flash_rd_addr_i = dma_pkg::wb_addr_t'(idx);
    #1;
    check_value($sformatf("flash_rd_data_o[%0d]", idx), flash_rd_data_o, exp);
  endtask

  // The dump holds the logged events oldest first, then the end marker.
  task automatic check_dump();
    int n;
    n = event_log.size();
    for (int i = 0; i < n; i++) begin
      read_flash(i, {1'b0, event_log[i]});
    end
    read_flash(n, `DMA_VS_END);
    event_log.delete();
  endtask

  initial begin
    soft_reset      = 1'b1;
    dma_crash_i     = 1'b0;
    prog_we_i       = 1'b0;
    prog_addr_i     = '0;
    prog_data_i     = '0;
    event_valid_i   = 1'b0;
    event_data_i    = '0;
    cfg_rd_addr_i   = '0;
    flash_rd_addr_i = '0;

    program_nv();

    // Normal boot.
    run_boot(1'b0);
    check_config();

    // Crash dump after the ring has wrapped.
    // New FROM contents show that the copies after the dump really ran.
    log_events(70);
    program_nv();
    run_boot(1'b1);
    check_dump();
    check_config();

    // Only events logged since the last dump.
    log_events(5);
    program_nv();
    run_boot(1'b1);
    check_dump();
    check_config();

    // Nothing logged.
    program_nv();
    run_boot(1'b1);
    check_dump();
    check_config();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* hw/dma_subsys.sv */
`timescale 1ns/1ps

module dma_subsys (
  input  logic              wb_clk_i,
  input  logic              soft_reset,
  input  logic              dma_crash_i,
  input  logic              prog_we_i,
  input  dma_pkg::wb_addr_t prog_addr_i,
  input  dma_pkg::wb_data_t prog_data_i,
  input  logic              event_valid_i,
  input  dma_pkg::event_t   event_data_i,
  input  dma_pkg::wb_addr_t cfg_rd_addr_i,
  input  dma_pkg::wb_addr_t flash_rd_addr_i,
  output logic              dma_done_o,
  output dma_pkg::wb_data_t cfg_rd_data_o,
  output dma_pkg::wb_data_t flash_rd_data_o
);

  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  dma_pkg::wb_addr_t wb_adr;
  dma_pkg::wb_data_t wb_wdat;
  dma_pkg::wb_data_t wb_rdat;
  logic              wb_ack;
  logic              wb_err;
  logic              nv_stb;
  logic              nv_ack;
  dma_pkg::wb_data_t nv_dat;
  logic              cfg_stb;
  logic              cfg_ack;
  logic              vs_stb;
  logic              vs_ack;
  dma_pkg::wb_data_t vs_dat;

  dma_engine dma_engine_inst (
    .wb_clk_i   (wb_clk_i),
    .soft_reset (soft_reset),
    .dma_crash_i(dma_crash_i),
    .wb_dat_i   (wb_rdat),
    .wb_ack_i   (wb_ack),
    .wb_err_i   (wb_err),
    .wb_cyc_o   (wb_cyc),
    .wb_stb_o   (wb_stb),
    .wb_we_o    (wb_we),
    .wb_adr_o   (wb_adr),
    .wb_dat_o   (wb_wdat),
    .dma_done_o (dma_done_o)
  );

  wb_addr_decoder wb_addr_decoder_inst (
    .wb_clk_i  (wb_clk_i),
    .soft_reset(soft_reset),
    .m_cyc_i   (wb_cyc),
    .m_stb_i   (wb_stb),
    .m_adr_i   (wb_adr),
    .nv_ack_i  (nv_ack),
    .nv_dat_i  (nv_dat),
    .cfg_ack_i (cfg_ack),
    .vs_ack_i  (vs_ack),
    .vs_dat_i  (vs_dat),
    .nv_stb_o  (nv_stb),
    .cfg_stb_o (cfg_stb),
    .vs_stb_o  (vs_stb),
    .m_dat_o   (wb_rdat),
    .m_ack_o   (wb_ack),
    .m_err_o   (wb_err)
  );

  nv_memory nv_memory_inst (
    .wb_clk_i       (wb_clk_i),
    .soft_reset     (soft_reset),
    .stb_i          (nv_stb),
    .we_i           (wb_we),
    .adr_i          (wb_adr),
    .dat_i          (wb_wdat),
    .prog_we_i      (prog_we_i),
    .prog_addr_i    (prog_addr_i),
    .prog_data_i    (prog_data_i),
    .flash_rd_addr_i(flash_rd_addr_i),
    .dat_o          (nv_dat),
    .ack_o          (nv_ack),
    .flash_rd_data_o(flash_rd_data_o)
  );

  config_regs config_regs_inst (
    .wb_clk_i     (wb_clk_i),
    .soft_reset   (soft_reset),
    .stb_i        (cfg_stb),
    .we_i         (wb_we),
    .adr_i        (wb_adr),
    .dat_i        (wb_wdat),
    .cfg_rd_addr_i(cfg_rd_addr_i),
    .ack_o        (cfg_ack),
    .cfg_rd_data_o(cfg_rd_data_o)
  );

  value_store value_store_inst (
    .wb_clk_i     (wb_clk_i),
    .soft_reset   (soft_reset),
    .stb_i        (vs_stb),
    .we_i         (wb_we),
    .dat_i        (wb_wdat),
    .event_valid_i(event_valid_i),
    .event_data_i (event_data_i),
    .dat_o        (vs_dat),
    .ack_o        (vs_ack)
  );

endmodule

/* hw/value_store.sv */
`timescale 1ns/1ps
`include "dma_defs.svh"

module value_store (
  input  logic              wb_clk_i,
  input  logic              soft_reset,
  input  logic              stb_i,
  input  logic              we_i,
  input  dma_pkg::wb_data_t dat_i,
  input  logic              event_valid_i,
  input  dma_pkg::event_t   event_data_i,
  output dma_pkg::wb_data_t dat_o,
  output logic              ack_o
);

  localparam int ptr_w = $clog2(`DMA_VS_DEPTH);

  dma_pkg::event_t  ring_mem [`DMA_VS_DEPTH];
  // Power-up state of the log.
  logic [ptr_w-1:0] wr_ptr_q = '0;
  logic [ptr_w:0]   count_q  = '0;
  logic             frozen_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w:0]   rd_left_q;
  logic             bus_rd;
  logic             freeze;
  logic             resume;
  logic             have_entry;

  assign bus_rd     = stb_i & ~we_i;
  assign freeze     = stb_i & we_i & (dat_i == 16'h0000);
  assign resume     = stb_i & we_i & (dat_i == `DMA_VS_RESUME);
  assign have_entry = frozen_q & (rd_left_q != '0);

  always_ff @(posedge wb_clk_i) begin
    if (resume) begin
      count_q <= '0;
    end else if (!frozen_q && !freeze && event_valid_i) begin
      ring_mem[wr_ptr_q] <= event_data_i;
      wr_ptr_q           <= wr_ptr_q + 1'b1;
      if (count_q != `DMA_VS_DEPTH) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      frozen_q  <= 1'b0;
      rd_left_q <= '0;
      ack_o     <= 1'b0;
    end else begin
      ack_o <= stb_i;
      if (freeze) begin
        frozen_q  <= 1'b1;
        rd_left_q <= count_q;
      end else if (resume) begin
        frozen_q  <= 1'b0;
        rd_left_q <= '0;
      end else if (bus_rd && have_entry) begin
        rd_left_q <= rd_left_q - 1'b1;
      end
    end
  end

  // Readout cursor starts at the oldest entry.
  always_ff @(posedge wb_clk_i) begin
    if (freeze) begin
      rd_ptr_q <= wr_ptr_q - count_q[ptr_w-1:0];
    end else if (bus_rd && have_entry) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
    if (bus_rd) begin
      dat_o <= have_entry ? {1'b0, ring_mem[rd_ptr_q]} : `DMA_VS_END;
    end
  end

endmodule

/* hw/config_regs.sv */
`timescale 1ns/1ps
`include "dma_defs.svh"

module config_regs (
  input  logic              wb_clk_i,
  input  logic              soft_reset,
  input  logic              stb_i,
  input  logic              we_i,
  input  dma_pkg::wb_addr_t adr_i,
  input  dma_pkg::wb_data_t dat_i,
  input  dma_pkg::wb_addr_t cfg_rd_addr_i,
  output logic              ack_o,
  output dma_pkg::wb_data_t cfg_rd_data_o
);

  localparam int lc_aw  = $clog2(`DMA_LC_COUNT);
  localparam int acm_aw = $clog2(`DMA_ACM_COUNT);

  dma_pkg::wb_data_t lc_q  [`DMA_LC_COUNT];
  dma_pkg::wb_data_t acm_q [`DMA_ACM_COUNT];
  dma_pkg::wb_data_t sys_q;
  dma_pkg::wb_addr_t lc_off;
  dma_pkg::wb_addr_t acm_off;
  dma_pkg::wb_addr_t rd_lc_off;
  dma_pkg::wb_addr_t rd_acm_off;

  assign lc_off     = adr_i - `DMA_LC_THRESHS_A;
  assign acm_off    = adr_i - `DMA_ACM_AQUADS_A;
  assign rd_lc_off  = cfg_rd_addr_i - `DMA_LC_THRESHS_A;
  assign rd_acm_off = cfg_rd_addr_i - `DMA_ACM_AQUADS_A;

  always_ff @(posedge wb_clk_i) begin
    if (stb_i && we_i) begin
      if (`DMA_IN_RANGE(adr_i, `DMA_LC_THRESHS_A, `DMA_LC_COUNT)) begin
        lc_q[lc_off[lc_aw-1:0]] <= dat_i;
      end else if (`DMA_IN_RANGE(adr_i, `DMA_ACM_AQUADS_A, `DMA_ACM_COUNT)) begin
        acm_q[acm_off[acm_aw-1:0]] <= dat_i;
      end else if (adr_i == `DMA_SYSCONFIG_A) begin
        sys_q <= dat_i;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= stb_i;
    end
  end

  always_comb begin
    cfg_rd_data_o = 16'h0000;
    if (`DMA_IN_RANGE(cfg_rd_addr_i, `DMA_LC_THRESHS_A, `DMA_LC_COUNT)) begin
      cfg_rd_data_o = lc_q[rd_lc_off[lc_aw-1:0]];
    end else if (`DMA_IN_RANGE(cfg_rd_addr_i, `DMA_ACM_AQUADS_A, `DMA_ACM_COUNT)) begin
      cfg_rd_data_o = acm_q[rd_acm_off[acm_aw-1:0]];
    end else if (cfg_rd_addr_i == `DMA_SYSCONFIG_A) begin
      cfg_rd_data_o = sys_q;
    end
  end

endmodule

/* hw/nv_memory.sv */
`timescale 1ns/1ps
`include "dma_defs.svh"

module nv_memory (
  input  logic              wb_clk_i,
  input  logic              soft_reset,
  input  logic              stb_i,
  input  logic              we_i,
  input  dma_pkg::wb_addr_t adr_i,
  input  dma_pkg::wb_data_t dat_i,
  input  logic              prog_we_i,
  input  dma_pkg::wb_addr_t prog_addr_i,
  input  dma_pkg::wb_data_t prog_data_i,
  input  dma_pkg::wb_addr_t flash_rd_addr_i,
  output dma_pkg::wb_data_t dat_o,
  output logic              ack_o,
  output dma_pkg::wb_data_t flash_rd_data_o
);

  localparam int from_aw  = $clog2(`DMA_FROM_WORDS);
  localparam int flash_aw = $clog2(`DMA_FLASH_WORDS);

  dma_pkg::wb_data_t from_mem  [`DMA_FROM_WORDS];
  dma_pkg::wb_data_t flash_mem [`DMA_FLASH_WORDS];
  dma_pkg::wb_data_t flash_sys;
  dma_pkg::wb_addr_t bus_off;
  dma_pkg::wb_addr_t prog_off;
  logic              bus_in_flash;

  assign bus_off      = adr_i - `DMA_FLASH_A;
  assign prog_off     = prog_addr_i - `DMA_FLASH_A;
  assign bus_in_flash = `DMA_IN_RANGE(adr_i, `DMA_FLASH_A, `DMA_FLASH_WORDS);

  always_ff @(posedge wb_clk_i) begin
    if (prog_we_i) begin
      if (prog_addr_i < `DMA_FROM_WORDS) begin
        from_mem[prog_addr_i[from_aw-1:0]] <= prog_data_i;
      end
      if (`DMA_IN_RANGE(prog_addr_i, `DMA_FLASH_A, `DMA_FLASH_WORDS)) begin
        flash_mem[prog_off[flash_aw-1:0]] <= prog_data_i;
      end
      if (prog_addr_i == `DMA_FLASH_SYSCONFIG_A) begin
        flash_sys <= prog_data_i;
      end
    end
    // The bus can only write the dump region.
    if (stb_i && we_i && bus_in_flash) begin
      flash_mem[bus_off[flash_aw-1:0]] <= dat_i;
    end
    if (stb_i && !we_i) begin
      if (adr_i < `DMA_FROM_WORDS) begin
        dat_o <= from_mem[adr_i[from_aw-1:0]];
      end else if (bus_in_flash) begin
        dat_o <= flash_mem[bus_off[flash_aw-1:0]];
      end else if (adr_i == `DMA_FLASH_SYSCONFIG_A) begin
        dat_o <= flash_sys;
      end else begin
        dat_o <= 16'h0000;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= stb_i;
    end
  end

  assign flash_rd_data_o = (flash_rd_addr_i < `DMA_FLASH_WORDS) ?
                           flash_mem[flash_rd_addr_i[flash_aw-1:0]] : 16'h0000;

endmodule

/* hw/wb_addr_decoder.sv */
`timescale 1ns/1ps
`include "dma_defs.svh"

module wb_addr_decoder (
  input  logic              wb_clk_i,
  input  logic              soft_reset,
  input  logic              m_cyc_i,
  input  logic              m_stb_i,
  input  dma_pkg::wb_addr_t m_adr_i,
  input  logic              nv_ack_i,
  input  dma_pkg::wb_data_t nv_dat_i,
  input  logic              cfg_ack_i,
  input  logic              vs_ack_i,
  input  dma_pkg::wb_data_t vs_dat_i,
  output logic              nv_stb_o,
  output logic              cfg_stb_o,
  output logic              vs_stb_o,
  output dma_pkg::wb_data_t m_dat_o,
  output logic              m_ack_o,
  output logic              m_err_o
);

  logic req;
  logic hit_nv;
  logic hit_cfg;
  logic hit_vs;
  logic nv_sel_q;
  logic vs_sel_q;
  logic err_q;

  assign req     = m_cyc_i & m_stb_i;
  assign hit_nv  = (m_adr_i < `DMA_FROM_WORDS) ||
                   `DMA_IN_RANGE(m_adr_i, `DMA_FLASH_A, `DMA_FLASH_WORDS) ||
                   (m_adr_i == `DMA_FLASH_SYSCONFIG_A);
  assign hit_cfg = `DMA_IN_RANGE(m_adr_i, `DMA_LC_THRESHS_A, `DMA_LC_COUNT) ||
                   `DMA_IN_RANGE(m_adr_i, `DMA_ACM_AQUADS_A, `DMA_ACM_COUNT) ||
                   (m_adr_i == `DMA_SYSCONFIG_A);
  assign hit_vs  = (m_adr_i == `DMA_VS_INDIRECT_A);

  assign nv_stb_o  = req & hit_nv;
  assign cfg_stb_o = req & hit_cfg;
  assign vs_stb_o  = req & hit_vs;

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      nv_sel_q <= 1'b0;
      vs_sel_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      nv_sel_q <= nv_stb_o;
      vs_sel_q <= vs_stb_o;
      err_q    <= req & ~(hit_nv | hit_cfg | hit_vs);
    end
  end

  // Config registers have no bus read path, so they fall through to zero.
  assign m_dat_o = nv_sel_q ? nv_dat_i : (vs_sel_q ? vs_dat_i : 16'h0000);
  assign m_ack_o = nv_ack_i | cfg_ack_i | vs_ack_i;
  assign m_err_o = err_q;

endmodule

/* hw/dma_engine.sv */
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_engine (
  input  logic              wb_clk_i,
  input  logic              soft_reset,
  input  logic              dma_crash_i,
  input  dma_pkg::wb_data_t wb_dat_i,
  input  logic              wb_ack_i,
  input  logic              wb_err_i,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output dma_pkg::wb_addr_t wb_adr_o,
  output dma_pkg::wb_data_t wb_dat_o,
  output logic              dma_done_o
);

  localparam dma_pkg::progress_t lc_last  = dma_pkg::progress_t'(`DMA_LC_COUNT - 1);
  localparam dma_pkg::progress_t acm_last = dma_pkg::progress_t'(`DMA_ACM_COUNT - 1);

  dma_pkg::dma_mode_e mode_q;
  dma_pkg::dma_step_e step_q;
  dma_pkg::progress_t progress_q;
  logic               stb_q;
  logic               last_q;
  logic               bus_done;
  logic               item_wr;
  dma_pkg::wb_addr_t  prog_adr;
  dma_pkg::wb_addr_t  rd_adr;
  dma_pkg::wb_addr_t  wr_adr;
  dma_pkg::wb_data_t  wr_dat;
  dma_pkg::wb_data_t  cmd_dat;

  assign bus_done = wb_ack_i | wb_err_i;
  // The write half of an item goes out in the cycle its read is acked.
  assign item_wr  = (step_q == dma_pkg::step_read_wait) & bus_done;
  assign prog_adr = dma_pkg::wb_addr_t'(progress_q);
  assign cmd_dat  = (progress_q == '0) ? 16'h0000 : `DMA_VS_RESUME;

  always_comb begin
    rd_adr = `DMA_VS_INDIRECT_A;
    wr_adr = `DMA_FLASH_A + prog_adr - 16'd1;
    wr_dat = wb_dat_i;
    case (mode_q)
      dma_pkg::mode_lc: begin
        rd_adr = `DMA_FROM_LC_A + prog_adr;
        wr_adr = `DMA_LC_THRESHS_A + prog_adr;
        // 8'hff in FROM disables the too-high check.
        wr_dat = (wb_dat_i == 16'h00ff) ? 16'h0fff : {wb_dat_i[11:0], 4'h0};
      end
      dma_pkg::mode_acm: begin
        rd_adr = `DMA_FROM_ACM_A + prog_adr;
        wr_adr = `DMA_ACM_AQUADS_A + prog_adr;
      end
      dma_pkg::mode_sysconfig: begin
        rd_adr = `DMA_FLASH_SYSCONFIG_A;
        wr_adr = `DMA_SYSCONFIG_A;
      end
      default: begin
      end
    endcase
  end

  assign wb_stb_o   = stb_q | item_wr;
  assign wb_cyc_o   = wb_stb_o;
  assign wb_we_o    = item_wr | (step_q == dma_pkg::step_close_wait);
  assign wb_adr_o   = item_wr ? wr_adr : rd_adr;
  assign wb_dat_o   = (step_q == dma_pkg::step_close_wait) ? cmd_dat : wr_dat;
  assign dma_done_o = (mode_q == dma_pkg::mode_done);

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      mode_q     <= dma_crash_i ? dma_pkg::mode_flash : dma_pkg::mode_lc;
      step_q     <= dma_pkg::step_issue;
      progress_q <= '0;
      stb_q      <= 1'b0;
    end else begin
      stb_q <= 1'b0;
      case (step_q)
        dma_pkg::step_issue: begin
          if (mode_q != dma_pkg::mode_done) begin
            stb_q  <= 1'b1;
            step_q <= (mode_q == dma_pkg::mode_flash) ? dma_pkg::step_close_wait :
                                                        dma_pkg::step_read_wait;
          end
        end
        dma_pkg::step_read_wait: begin
          if (bus_done) begin
            last_q <= wb_dat_i[15];
            step_q <= dma_pkg::step_write_wait;
          end
        end
        dma_pkg::step_write_wait: begin
          if (bus_done) begin
            stb_q  <= 1'b1;
            step_q <= dma_pkg::step_read_wait;
            case (mode_q)
              dma_pkg::mode_flash: begin
                // Release the ring once the end marker is written.
                if (last_q || progress_q == '1) begin
                  step_q <= dma_pkg::step_close_wait;
                end else begin
                  progress_q <= progress_q + 1'b1;
                end
              end
              dma_pkg::mode_lc: begin
                if (progress_q == lc_last) begin
                  mode_q     <= dma_pkg::mode_acm;
                  progress_q <= '0;
                end else begin
                  progress_q <= progress_q + 1'b1;
                end
              end
              dma_pkg::mode_acm: begin
                if (progress_q == acm_last) begin
                  mode_q     <= dma_pkg::mode_sysconfig;
                  progress_q <= '0;
                end else begin
                  progress_q <= progress_q + 1'b1;
                end
              end
              default: begin
                stb_q  <= 1'b0;
                step_q <= dma_pkg::step_issue;
                mode_q <= dma_pkg::mode_done;
              end
            endcase
          end
        end
        default: begin
          // Open (write 0) or close (resume) of the dump.
          if (bus_done) begin
            stb_q  <= 1'b1;
            step_q <= dma_pkg::step_read_wait;
            if (progress_q == '0) begin
              progress_q <= dma_pkg::progress_t'(1);
            end else begin
              mode_q     <= dma_pkg::mode_lc;
              progress_q <= '0;
            end
          end
        end
      endcase
    end
  end

endmodule

/* hw/dma_pkg.sv */
package dma_pkg;

  typedef logic [15:0] wb_addr_t;
  typedef logic [15:0] wb_data_t;
  typedef logic [14:0] event_t;
  typedef logic [12:0] progress_t;

  typedef enum logic [2:0] {
    mode_flash,
    mode_lc,
    mode_acm,
    mode_sysconfig,
    mode_done
  } dma_mode_e;

  typedef enum logic [1:0] {
    step_issue,
    step_read_wait,
    step_write_wait,
    step_close_wait
  } dma_step_e;

endpackage

/* include/dma_defs.svh */
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Word addresses on the boot bus.
`define DMA_FROM_ACM_A        16'd0
`define DMA_FROM_LC_A         16'd40
`define DMA_LC_THRESHS_A      16'd128
`define DMA_ACM_AQUADS_A      16'd384
`define DMA_VS_INDIRECT_A     16'd512
`define DMA_SYSCONFIG_A       16'd576
`define DMA_FLASH_A           16'd1024
`define DMA_FLASH_SYSCONFIG_A 16'hffff

// Block lengths and memory sizes, in words.
`define DMA_LC_COUNT    64
`define DMA_ACM_COUNT   40
`define DMA_FROM_WORDS  128
`define DMA_FLASH_WORDS 256
`define DMA_VS_DEPTH    64

// Value-store command and marker words.
`define DMA_VS_END    16'h8000
`define DMA_VS_RESUME 16'hffff

// True when address a lies in [base, base + len).
`define DMA_IN_RANGE(a, base, len) (((a) >= (base)) && ((a) < (base) + (len)))

`endif
